// ==== countConnected_defs.svh ====
`ifndef COUNT_CONNECTED_DEFS_SVH
`define COUNT_CONNECTED_DEFS_SVH

// seed stage: input register, two analysis stages, one alignment stage
`define NEW_SEED_DEPTH 4

// one lattice closure, seven layers split over this many registers
`define CLOSURE_DEPTH 2

// extension result inside exploration, right after the down closure
`define DOWN_OFFSET (2 * `CLOSURE_DEPTH + 1)

// exploration input to leftover, run-end and grab flag
`define EXPLORATION_DEPTH 7

// registers around the loop, also the number of slots in flight
`define LOOP_STAGES 16

// return paths so every slot comes back after exactly LOOP_STAGES
`define LEFTOVER_RETURN_DEPTH (`LOOP_STAGES - 1 - `NEW_SEED_DEPTH - `EXPLORATION_DEPTH)
`define EXTEND_RETURN_DEPTH (`LOOP_STAGES - 1 - `DOWN_OFFSET)

// extra slack between the loop and the result consumer
`define OUTPUT_DEPTH 3

`endif

// ==== countConnectedPkg.sv ====
package countConnectedPkg;

    // one bit per corner of the 7-dimensional hypercube
    typedef logic [127:0] graph_t;

    // at most 35 incomparable components, so 6 bits never overflow
    typedef logic [5:0] count_t;

    // caller data, carried unchanged from start to done
    typedef logic [9:0] tag_t;

endpackage

// ==== delayLine.sv ====
`timescale 1ns/1ps

module delayLine #(
    parameter type payload_t = logic,
    parameter int CYCLES = 1
) (
    input  logic     clk,
    input  logic     rstN,
    input  payload_t d,
    output payload_t q
);

    payload_t stages [CYCLES];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < CYCLES; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= d;
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i - 1];
            end
        end
    end

    assign q = stages[CYCLES - 1];

endmodule

// ==== firstBitAnalysis.sv ====
`timescale 1ns/1ps

module firstBitAnalysis (
    input  logic                      clk,
    input  countConnectedPkg::graph_t graphIn,
    output logic [1:0]                hasBit64,
    output logic [31:0]               hasFirstBit4,
    output logic [7:0]                hasFirstBit16
);

    logic [31:0] hasBit4;
    logic [7:0]  hasBit16;
    logic [1:0]  hasBit64Mid;
    logic [31:0] firstBit4Mid;
    logic [7:0]  firstBit16Mid;

    // one-hot lowest set flag of a group of four
    function automatic logic [3:0] lowestOfFour(input logic [3:0] v);
        return v & (~v + 4'd1);
    endfunction

    // nibble and 16-bit block OR trees
    always_ff @(posedge clk) begin
        for (int i = 0; i < 32; i++) begin
            hasBit4[i] <= |graphIn[4 * i +: 4];
        end
        for (int i = 0; i < 8; i++) begin
            hasBit16[i] <= |graphIn[16 * i +: 16];
        end
    end

    // halves, plus first nibble per block and first block per half
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            hasBit64Mid[i] <= |hasBit16[4 * i +: 4];
            firstBit16Mid[4 * i +: 4] <= lowestOfFour(hasBit16[4 * i +: 4]);
        end
        for (int i = 0; i < 8; i++) begin
            firstBit4Mid[4 * i +: 4] <= lowestOfFour(hasBit4[4 * i +: 4]);
        end
    end

    // alignment stage
    always_ff @(posedge clk) begin
        hasBit64 <= hasBit64Mid;
        hasFirstBit4 <= firstBit4Mid;
        hasFirstBit16 <= firstBit16Mid;
    end

endmodule

// ==== newSeedPipeline.sv ====
`timescale 1ns/1ps
`include "countConnected_defs.svh"

module newSeedPipeline (
    input  logic                      clk,
    input  countConnectedPkg::graph_t graphIn,
    input  countConnectedPkg::graph_t extendedIn,
    input  logic                      grabSeed,
    output logic                      incrementCount,
    output countConnectedPkg::graph_t extendingOut
);

    import countConnectedPkg::*;

    typedef struct packed {
        logic   grab;
        graph_t graph;
    } seedJob_t;

    seedJob_t    jobStart;
    seedJob_t    jobAligned;
    logic [1:0]  hasBit64;
    logic [31:0] hasFirstBit4;
    logic [7:0]  hasFirstBit16;
    graph_t      seed;

    always_ff @(posedge clk) begin
        jobStart.grab <= grabSeed;
        jobStart.graph <= graphIn;
    end

    firstBitAnalysis analysis (
        .clk,
        .graphIn(jobStart.graph),
        .hasBit64,
        .hasFirstBit4,
        .hasFirstBit16
    );

    // graph and grab flag wait for the analysis
    delayLine #(
        .payload_t(seedJob_t),
        .CYCLES(`NEW_SEED_DEPTH - 1)
    ) jobDelay (
        .clk,
        .rstN(1'b1),
        .d(jobStart),
        .q(jobAligned)
    );

    // lowest set bit, from nibble, block and half flags
    for (genvar b = 0; b < 128; b++) begin : gSeed
        localparam int NIBBLE = b / 4;
        localparam int BLOCK = b / 16;
        localparam logic [3:0] BELOW = 4'((1 << (b % 4)) - 1);

        logic firstInNibble;
        logic blockSelected;

        assign firstInNibble = jobAligned.graph[b]
            && ((jobAligned.graph[4 * NIBBLE +: 4] & BELOW) == 4'b0);
        // upper half only counts when the lower half is empty
        assign blockSelected = hasFirstBit16[BLOCK] && (b < 64 || !hasBit64[0]);
        assign seed[b] = firstInNibble && hasFirstBit4[NIBBLE] && blockSelected;
    end

    assign extendingOut = jobAligned.grab ? seed : extendedIn;

    // a new component only if something is left to seed from
    assign incrementCount = jobAligned.grab & (|hasBit64);

endmodule

// ==== latticeClosure.sv ====
`timescale 1ns/1ps
`include "countConnected_defs.svh"

module latticeClosure #(
    parameter bit UPWARD = 1'b1
) (
    input  logic                      clk,
    input  countConnectedPkg::graph_t d,
    output countConnectedPkg::graph_t q
);

    import countConnectedPkg::*;

    localparam int LAYERS = 7;
    localparam int PER_STAGE = (LAYERS + `CLOSURE_DEPTH - 1) / `CLOSURE_DEPTH;

    graph_t stageQ [1:`CLOSURE_DEPTH];

    // one layer per index bit, each node ORs in its neighbour across that bit
    function automatic graph_t closeLayers(input graph_t v, input int first, input int last);
        graph_t r;
        int     mate;
        r = v;
        for (int k = first; k < last && k < LAYERS; k++) begin
            for (int n = 0; n < 128; n++) begin
                mate = n ^ (1 << k);
                // upward nodes look below, downward nodes look above
                if (((n >> k) & 1) == int'(UPWARD)) begin
                    r[n] = r[n] | r[mate];
                end
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        stageQ[1] <= closeLayers(d, 0, PER_STAGE);
        for (int s = 2; s <= `CLOSURE_DEPTH; s++) begin
            stageQ[s] <= closeLayers(stageQ[s - 1], (s - 1) * PER_STAGE, s * PER_STAGE);
        end
    end

    assign q = stageQ[`CLOSURE_DEPTH];

endmodule

// ==== explorationPipeline.sv ====
`timescale 1ns/1ps
`include "countConnected_defs.svh"

module explorationPipeline (
    input  logic                      clk,
    input  countConnectedPkg::graph_t leftoverIn,
    input  countConnectedPkg::graph_t extendingIn,
    output countConnectedPkg::graph_t leftoverOut,
    output countConnectedPkg::graph_t extendedOut,
    output logic                      runEnd,
    output logic                      grabSeedOut
);

    import countConnectedPkg::*;

    localparam int UP_DONE = `CLOSURE_DEPTH;
    localparam int DOWN_DONE = 2 * `CLOSURE_DEPTH;

    graph_t      leftoverDly [1:`EXPLORATION_DEPTH];
    graph_t      midDly [UP_DONE + 1:`DOWN_OFFSET];
    graph_t      upClosed;
    graph_t      midPoint;
    graph_t      downClosed;
    graph_t      reducedDown;
    graph_t      reducedSum;
    graph_t      reducedExpl;
    logic [7:0]  nonEmptyPart;
    logic [15:0] sameAsMidPart;
    logic        reducedEmpty;
    logic        extensionFinished;

    latticeClosure #(.UPWARD(1'b1)) upClosure (
        .clk,
        .d(extendingIn),
        .q(upClosed)
    );

    // supersets that are still left over
    assign midPoint = upClosed & leftoverDly[UP_DONE];

    latticeClosure #(.UPWARD(1'b0)) downClosure (
        .clk,
        .d(midPoint),
        .q(downClosed)
    );

    always_ff @(posedge clk) begin
        leftoverDly[1] <= leftoverIn;
        for (int s = 2; s <= `EXPLORATION_DEPTH; s++) begin
            leftoverDly[s] <= leftoverDly[s - 1];
        end
        midDly[UP_DONE + 1] <= midPoint;
        for (int s = UP_DONE + 2; s <= `DOWN_OFFSET; s++) begin
            midDly[s] <= midDly[s - 1];
        end
    end

    // extension and reduced graph, ready at DOWN_OFFSET
    always_ff @(posedge clk) begin
        extendedOut <= downClosed & leftoverDly[DOWN_DONE];
        reducedDown <= leftoverDly[DOWN_DONE] & ~downClosed;
    end

    // partial summaries over 16-bit and 8-bit slices
    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            nonEmptyPart[i] <= |reducedDown[16 * i +: 16];
        end
        for (int i = 0; i < 16; i++) begin
            sameAsMidPart[i] <= extendedOut[8 * i +: 8] == midDly[`DOWN_OFFSET][8 * i +: 8];
        end
        reducedSum <= reducedDown;
    end

    assign reducedEmpty = ~|nonEmptyPart;
    // down closure added nothing, so the component is complete
    assign extensionFinished = &sameAsMidPart;

    // an empty remainder also ends the component
    always_ff @(posedge clk) begin
        runEnd <= reducedEmpty;
        grabSeedOut <= reducedEmpty | extensionFinished;
        reducedExpl <= reducedSum;
    end

    assign leftoverOut = grabSeedOut ? reducedExpl : leftoverDly[`EXPLORATION_DEPTH];

endmodule

// ==== countConnectedLoop.sv ====
`timescale 1ns/1ps
`include "countConnected_defs.svh"

module countConnectedLoop (
    input  logic                      clk,
    input  logic                      rstN,
    input  countConnectedPkg::graph_t graphIn,
    input  logic                      start,
    input  countConnectedPkg::tag_t   tagIn,
    input  logic                      runEndIn,
    input  countConnectedPkg::graph_t extendedIn,
    input  countConnectedPkg::graph_t leftoverIn,
    input  logic                      grabSeedIn,
    input  logic                      validIn,
    input  countConnectedPkg::count_t countIn,
    input  countConnectedPkg::tag_t   tagLoopIn,
    output logic                      runEndOut,
    output countConnectedPkg::graph_t extendedOut,
    output countConnectedPkg::graph_t leftoverOut,
    output logic                      grabSeedOut,
    output logic                      validOut,
    output countConnectedPkg::count_t countOut,
    output countConnectedPkg::tag_t   tagLoopOut
);

    import countConnectedPkg::*;

    typedef struct packed {
        logic   accept;
        logic   valid;
        count_t count;
    } seedSide_t;

    typedef struct packed {
        logic   valid;
        count_t count;
    } explSide_t;

    logic      accept;
    graph_t    leftoverWire;
    logic      incSeed;
    graph_t    extendingSeed;
    graph_t    extendingMid;
    graph_t    leftoverMid;
    graph_t    leftoverExpl;
    logic      runEndExpl;
    logic      grabExpl;
    count_t    countSeed;
    seedSide_t seedSideIn;
    seedSide_t seedSideQ;
    explSide_t explSideIn;
    explSide_t explSideQ;

    // a new graph only enters a free slot
    assign accept = start & runEndIn;
    assign leftoverWire = accept ? graphIn : leftoverIn;
    assign validOut = accept | (validIn & ~runEndIn);
    assign tagLoopOut = accept ? tagIn : tagLoopIn;

    newSeedPipeline seedStage (
        .clk,
        .graphIn(leftoverWire),
        .extendedIn,
        .grabSeed(grabSeedIn),
        .incrementCount(incSeed),
        .extendingOut(extendingSeed)
    );

    assign seedSideIn = '{accept: accept, valid: validOut, count: countIn};

    delayLine #(.payload_t(seedSide_t), .CYCLES(`NEW_SEED_DEPTH)) seedSideDelay (
        .clk,
        .rstN,
        .d(seedSideIn),
        .q(seedSideQ)
    );

    assign countSeed = (seedSideQ.accept ? count_t'(0) : seedSideQ.count) + count_t'(incSeed);

    delayLine #(.payload_t(graph_t), .CYCLES(1)) extendingReg (
        .clk,
        .rstN,
        .d(extendingSeed),
        .q(extendingMid)
    );

    delayLine #(.payload_t(graph_t), .CYCLES(`NEW_SEED_DEPTH + 1)) leftoverDelay (
        .clk,
        .rstN,
        .d(leftoverWire),
        .q(leftoverMid)
    );

    explorationPipeline explore (
        .clk,
        .leftoverIn(leftoverMid),
        .extendingIn(extendingMid),
        .leftoverOut(leftoverExpl),
        .extendedOut,
        .runEnd(runEndExpl),
        .grabSeedOut(grabExpl)
    );

    assign explSideIn = '{valid: seedSideQ.valid, count: countSeed};

    delayLine #(.payload_t(explSide_t), .CYCLES(`EXPLORATION_DEPTH + 1)) explSideDelay (
        .clk,
        .rstN,
        .d(explSideIn),
        .q(explSideQ)
    );

    // an idle slot always returns empty and free
    assign runEndOut = runEndExpl | ~explSideQ.valid;
    assign grabSeedOut = grabExpl | ~explSideQ.valid;
    assign leftoverOut = explSideQ.valid ? leftoverExpl : '0;
    assign countOut = explSideQ.count;

endmodule

// ==== countConnectedCore.sv ====
`timescale 1ns/1ps
`include "countConnected_defs.svh"

module countConnectedCore (
    input  logic                      clk,
    input  logic                      rstN,
    output logic                      request,
    input  countConnectedPkg::graph_t graphIn,
    input  logic                      start,
    input  countConnectedPkg::tag_t   tagIn,
    output logic                      done,
    output countConnectedPkg::count_t count,
    output countConnectedPkg::tag_t   tagOut
);

    import countConnectedPkg::*;

    // flags stored inverted, so a cleared slot is free and ready to seed
    typedef struct packed {
        graph_t leftover;
        logic   busy;
        logic   extending;
        count_t count;
    } slotState_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } slotOwner_t;

    typedef struct packed {
        logic   done;
        count_t count;
        tag_t   tag;
    } result_t;

    logic       runEndIn;
    graph_t     extendedIn;
    graph_t     leftoverIn;
    logic       grabSeedIn;
    logic       validIn;
    count_t     countIn;
    tag_t       tagLoopIn;
    logic       runEndOut;
    graph_t     extendedOut;
    graph_t     leftoverOut;
    logic       grabSeedOut;
    logic       validOut;
    count_t     countOut;
    tag_t       tagLoopOut;
    slotState_t stateOut;
    slotState_t stateIn;
    slotOwner_t ownerOut;
    slotOwner_t ownerIn;
    result_t    resultIn;
    result_t    resultOut;

    countConnectedLoop loop (
        .clk, .rstN, .graphIn, .start, .tagIn,
        .runEndIn, .extendedIn, .leftoverIn, .grabSeedIn, .validIn, .countIn, .tagLoopIn,
        .runEndOut, .extendedOut, .leftoverOut, .grabSeedOut, .validOut, .countOut, .tagLoopOut
    );

    // extension comes back in time for the next seed decision
    delayLine #(.payload_t(graph_t), .CYCLES(`EXTEND_RETURN_DEPTH)) extendReturn (
        .clk, .rstN, .d(extendedOut), .q(extendedIn)
    );

    assign stateOut = '{leftover: leftoverOut, busy: ~runEndOut,
                        extending: ~grabSeedOut, count: countOut};

    delayLine #(.payload_t(slotState_t), .CYCLES(`LEFTOVER_RETURN_DEPTH)) stateReturn (
        .clk, .rstN, .d(stateOut), .q(stateIn)
    );

    assign leftoverIn = stateIn.leftover;
    assign runEndIn = ~stateIn.busy;
    assign grabSeedIn = ~stateIn.extending;
    assign countIn = stateIn.count;

    assign ownerOut = '{valid: validOut, tag: tagLoopOut};

    delayLine #(.payload_t(slotOwner_t), .CYCLES(`LOOP_STAGES)) ownerReturn (
        .clk, .rstN, .d(ownerOut), .q(ownerIn)
    );

    assign validIn = ownerIn.valid;
    assign tagLoopIn = ownerIn.tag;

    assign request = runEndIn;

    // a valid slot arriving with its run ended carries the final count
    assign resultIn = '{done: runEndIn & validIn, count: countIn, tag: tagLoopIn};

    delayLine #(.payload_t(result_t), .CYCLES(`OUTPUT_DEPTH)) resultDelay (
        .clk, .rstN, .d(resultIn), .q(resultOut)
    );

    assign done = resultOut.done;
    assign count = resultOut.count;
    assign tagOut = resultOut.tag;

endmodule

// ==== countConnectedTb.sv ====
`timescale 1ns/1ps
`include "countConnected_defs.svh"

module countConnectedTb;

    import countConnectedPkg::*;

    localparam int FINISH_LIMIT = 128 * `LOOP_STAGES;
    localparam int RANDOM_GRAPHS = 200;
    localparam int RANDOM_LIMIT = RANDOM_GRAPHS * FINISH_LIMIT;
    localparam tag_t IGNORED_TAG = 10'h3ff;

    logic   clk = 1'b0;
    logic   rstN;
    logic   request;
    graph_t graphIn;
    logic   start;
    tag_t   tagIn;
    logic   done;
    count_t count;
    tag_t   tagOut;

    integer seed;
    int     cycle;
    int     procErrors;
    int     assertErrors;
    int     accepted;
    int     doneCount;
    int     inFlight;
    tag_t   nextTag;

    // scoreboard indexed by tag
    logic   pending [1024];
    count_t expectedCount [1024];
    int     startCycle [1024];

    // reference for the done pulse of the current cycle
    logic   tagKnown;
    count_t expectedNow;
    int     latencyNow;

    countConnectedCore dut0 (
        .clk, .rstN, .request, .graphIn, .start, .tagIn, .done, .count, .tagOut
    );

    always #20 clk = ~clk;

    function automatic logic subsetRelated(input int a, input int b);
        return ((a & b) == a) || ((a & b) == b);
    endfunction

    // flood fill from the lowest leftover node, one component per seed
    function automatic int modelCount(input graph_t g);
        graph_t left;
        int     stack [$];
        int     node;
        int     components;
        left = g;
        components = 0;
        for (int s = 0; s < 128; s++) begin
            if (left[s]) begin
                components++;
                left[s] = 1'b0;
                stack.push_back(s);
                while (stack.size() > 0) begin
                    node = stack.pop_back();
                    for (int m = 0; m < 128; m++) begin
                        if (left[m] && subsetRelated(node, m)) begin
                            left[m] = 1'b0;
                            stack.push_back(m);
                        end
                    end
                end
            end
        end
        return components;
    endfunction

    // sparse graphs split into many components, dense ones mostly into one
    task automatic makeRandomGraph(output graph_t g);
        int          sparsity;
        logic [31:0] word;
        sparsity = $random(seed) & 3;
        for (int w = 0; w < 4; w++) begin
            word = $random(seed);
            for (int k = 0; k < sparsity; k++) begin
                word = word & $random(seed);
            end
            g[32 * w +: 32] = word;
        end
    endtask

    // one clock, then drop start and retire any done pulse
    task automatic nextCycle();
        @(posedge clk);
        #1;
        cycle++;
        start = 1'b0;
        tagKnown = 1'b0;
        expectedNow = '0;
        latencyNow = 0;
        if (done) begin
            doneCount++;
            tagKnown = pending[tagOut];
            if (tagKnown) begin
                expectedNow = expectedCount[tagOut];
                latencyNow = cycle - startCycle[tagOut];
                pending[tagOut] = 1'b0;
                inFlight--;
            end
        end
    endtask

    task automatic startGraph(input graph_t g, input count_t expected);
        graphIn = g;
        tagIn = nextTag;
        start = 1'b1;
        pending[nextTag] = 1'b1;
        expectedCount[nextTag] = expected;
        startCycle[nextTag] = cycle;
        inFlight++;
        accepted++;
        nextTag++;
    endtask

    // start while every slot is busy, must never come back as done
    task automatic driveIgnoredStart(input graph_t g);
        graphIn = g;
        tagIn = IGNORED_TAG;
        start = 1'b1;
    endtask

    task automatic waitRequest(input int limit);
        int waited;
        waited = 0;
        while (!request && waited < limit) begin
            nextCycle();
            waited++;
        end
        requestSeen: assert (request) else begin
            procErrors++;
            $display("request stayed low for %0d cycles", limit);
        end
    endtask

    task automatic waitIdle(input int limit);
        int waited;
        waited = 0;
        while (inFlight > 0 && waited < limit) begin
            nextCycle();
            waited++;
        end
        allFinished: assert (inFlight == 0) else begin
            procErrors++;
            $display("%0d graphs still running after %0d cycles", inFlight, limit);
        end
    endtask

    task automatic runOneGraph(input graph_t g, input count_t expected);
        waitRequest(`LOOP_STAGES);
        startGraph(g, expected);
        waitIdle(FINISH_LIMIT);
    endtask

    doneTagKnown: assert property (@(negedge clk) done |-> tagKnown) else begin
        assertErrors++;
        $display("done pulsed with tag %h, which no running graph carries", tagOut);
    end

    doneCountRight: assert property (@(negedge clk) (done && tagKnown) |-> count == expectedNow)
    else begin
        assertErrors++;
        $display("Fail count expected %h actual %h tag %h", expectedNow, count, tagOut);
    end

    doneInTime: assert property (@(negedge clk) (done && tagKnown) |-> latencyNow <= FINISH_LIMIT)
    else begin
        assertErrors++;
        $display("graph with tag %h needed %0d cycles, over the limit", tagOut, latencyNow);
    end

    // nothing running means every slot is free
    requestWhenIdle: assert property (@(negedge clk)
        (rstN && inFlight == 0 && cycle > 2 + `LOOP_STAGES) |-> request)
    else begin
        assertErrors++;
        $display("request low although no graph is running");
    end

    initial begin
        graph_t g;
        int     waited;
        int     randomStarted;
        seed = 32'hb274;
        rstN = 1'b0;
        start = 1'b0;
        graphIn = '0;
        tagIn = '0;
        cycle = 0;
        procErrors = 0;
        assertErrors = 0;
        accepted = 0;
        doneCount = 0;
        inFlight = 0;
        nextTag = 10'h001;
        tagKnown = 1'b0;
        expectedNow = '0;
        latencyNow = 0;
        for (int t = 0; t < 1024; t++) begin
            pending[t] = 1'b0;
            expectedCount[t] = '0;
            startCycle[t] = 0;
        end

        repeat (2) nextCycle();
        rstN = 1'b1;
        waitRequest(`LOOP_STAGES);

        // fixed graphs, one at a time
        runOneGraph('0, 6'd0);
        runOneGraph(graph_t'(1) << 37, 6'd1);
        // 0000011 and 0000100, neither is a subset of the other
        runOneGraph((graph_t'(1) << 3) | (graph_t'(1) << 4), 6'd2);
        g = '0;
        for (int k = 1; k <= 7; k++) begin
            g[(1 << k) - 1] = 1'b1;
        end
        runOneGraph(g, 6'd1);
        runOneGraph('1, 6'd1);

        // random graphs at every request, ignored starts while all slots are busy
        waited = 0;
        randomStarted = 0;
        while (randomStarted < RANDOM_GRAPHS && waited < RANDOM_LIMIT) begin
            nextCycle();
            waited++;
            if (request) begin
                makeRandomGraph(g);
                startGraph(g, count_t'(modelCount(g)));
                randomStarted++;
            end else if (($random(seed) & 3) == 0) begin
                makeRandomGraph(g);
                driveIgnoredStart(g);
            end
        end
        allStarted: assert (randomStarted == RANDOM_GRAPHS) else begin
            procErrors++;
            $display("only %0d random graphs were accepted", randomStarted);
        end
        waitIdle(FINISH_LIMIT);

        // quiet tail so that a stray done still shows up
        repeat (2 * `LOOP_STAGES) nextCycle();

        doneTotal: assert (doneCount == accepted) else begin
            procErrors++;
            $display("Fail done pulses expected %h actual %h", accepted, doneCount);
        end

        $display("assertion errors %0d, other errors %0d, graphs %0d, done pulses %0d",
                 assertErrors, procErrors, accepted, doneCount);
        if (assertErrors + procErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
countConnectedPkg.sv
delayLine.sv
firstBitAnalysis.sv
newSeedPipeline.sv
latticeClosure.sv
explorationPipeline.sv
countConnectedLoop.sv
countConnectedCore.sv
countConnectedTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f src.f --top-module countConnectedTb -o countConnectedSim \
    && ./obj_dir/countConnectedSim | tee /dev/stderr | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0
